/* fv_pkg.sv */
// shared widths, counts and vector types of the feature-vector store, imported by RTL and testbench
package fv_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int NUM_BANKS = 4;
    localparam int NUM_PE    = 4;
    localparam int ROW_W     = 6;

    localparam int DATA_W    = 16;
    localparam int BANK_W    = $clog2(NUM_BANKS);
    localparam int TAG_W     = $clog2(NUM_PE);
    localparam int ADDR_W    = ROW_W + BANK_W;
    // one extra bit so that a full store of 2**ADDR_W vectors can be counted
    localparam int COUNT_W   = ADDR_W + 1;

    // ========================================
    // types
    // ========================================
    // one feature-vector word
    typedef logic [DATA_W-1:0] fv_data_t;

    // bank select in the low bits, row in the upper bits
    typedef logic [ADDR_W-1:0] fv_addr_t;

    typedef logic [ROW_W-1:0] fv_row_t;

    typedef logic [BANK_W-1:0] bank_idx_t;

    // names the edge PE that gets the result
    typedef logic [TAG_W-1:0] pe_tag_t;

    typedef logic [COUNT_W-1:0] fv_count_t;

endpackage

/* fv_req_if.sv */
// head-of-queue request and pop strobe between the request FIFO and the memory controller
interface fv_req_if import fv_pkg::*; ();

    pe_tag_t  head_tag;
    fv_addr_t head_addr;
    logic     empty;
    // only raised while empty is low, the head advances on that edge
    logic     pop;

    modport fifo_side (
        output head_tag,
        output head_addr,
        output empty,
        input  pop
    );

    modport cntl_side (
        input  head_tag,
        input  head_addr,
        input  empty,
        output pop
    );

endinterface

/* fv_req_fifo.sv */
// request FIFO that queues PE read requests and presents the oldest one to the memory controller
module fv_req_fifo import fv_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_valid,
    input  pe_tag_t  wr_tag,
    input  fv_addr_t wr_addr,
    output logic     full,
    fv_req_if.fifo_side head
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // pointers carry one wrap bit above the index
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    pe_tag_t  tag_mem  [FIFO_DEPTH];
    fv_addr_t addr_mem [FIFO_DEPTH];

    logic do_write;
    logic do_read;

    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head.empty = (wr_ptr == rd_ptr);

    // a write while full is dropped
    assign do_write = wr_valid && !full;
    assign do_read  = head.pop && !head.empty;

    assign head.head_tag  = tag_mem[rd_ptr[PTR_W-1:0]];
    assign head.head_addr = addr_mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            tag_mem[wr_ptr[PTR_W-1:0]]  <= wr_tag;
            addr_mem[wr_ptr[PTR_W-1:0]] <= wr_addr;
        end
    end

endmodule

/* fv_mem_cntl.sv */
// memory controller that pops the head request and issues it to the bank picked by the address
module fv_mem_cntl import fv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    fv_req_if.cntl_side          head,
    input  logic [NUM_BANKS-1:0] busy,
    output logic [NUM_BANKS-1:0] issue,
    output pe_tag_t              issue_tag,
    output fv_row_t              issue_row
);

    bank_idx_t head_bank;
    fv_row_t   head_row;

    // ========================================
    // address decode
    // ========================================
    assign head_bank = head.head_addr[BANK_W-1:0];
    assign head_row  = head.head_addr[ADDR_W-1:BANK_W];

    // the head waits while its bank is busy, later requests wait behind it
    // so results keep request order
    assign head.pop = !head.empty && !busy[head_bank];

    // ========================================
    // issue register
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            issue <= '0;
        end else begin
            issue <= '0;
            if (head.pop) begin
                issue[head_bank] <= 1'b1;
            end
        end
    end

    // tag and row only matter while an issue bit is high
    always_ff @(posedge clk) begin
        if (head.pop) begin
            issue_tag <= head.head_tag;
            issue_row <= head_row;
        end
    end

endmodule

/* fv_bank_cntl.sv */
// one SRAM bank controller with fill writes, range-checked reads and a busy flag for the issuer
module fv_bank_cntl import fv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  fv_count_t num_fv,
    input  bank_idx_t bank_id,
    input  logic      issue,
    input  pe_tag_t   issue_tag,
    input  fv_row_t   issue_row,
    input  logic      fill_valid,
    input  fv_row_t   fill_row,
    input  fv_data_t  fill_data,
    output logic      busy,
    output logic      res_valid,
    output pe_tag_t   res_tag,
    output fv_data_t  res_data
);

    typedef enum logic {
        BANK_IDLE,
        BANK_READ
    } bank_state_t;

    bank_state_t state;

    fv_data_t mem [2**ROW_W];

    // an issue that met a fill waits here until the fill is gone
    logic    pend;
    pe_tag_t pend_tag;
    fv_row_t pend_row;

    fv_row_t  rd_row;
    pe_tag_t  rd_tag;
    fv_addr_t rd_addr;
    logic     in_range;
    logic     start_rd;

    always_comb begin
        rd_row   = pend ? pend_row : issue_row;
        rd_tag   = pend ? pend_tag : issue_tag;
        rd_addr  = {rd_row, bank_id};
        in_range = {1'b0, rd_addr} < num_fv;
        // a fill on this edge always wins over the read
        start_rd = (state == BANK_IDLE) && (issue || pend) && !fill_valid;
    end

    // covers the fill cycle, the issue cycle and the read cycle
    assign busy = fill_valid || issue || pend || (state == BANK_READ);

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BANK_IDLE;
            pend      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                BANK_IDLE: begin
                    if (start_rd) begin
                        state <= BANK_READ;
                        pend  <= 1'b0;
                    end else if (issue) begin
                        pend <= 1'b1;
                    end
                end
                BANK_READ: begin
                    state     <= BANK_IDLE;
                    res_valid <= 1'b1;
                end
                default: begin
                    state <= BANK_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // array and read data
    // ========================================
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            mem[fill_row] <= fill_data;
        end
        if (issue) begin
            pend_tag <= issue_tag;
            pend_row <= issue_row;
        end
        if (start_rd) begin
            res_tag  <= rd_tag;
            // vectors past the valid count read as zero without touching the array
            res_data <= in_range ? mem[rd_row] : '0;
        end
    end

endmodule

/* fv_pe_bus.sv */
// result bus that takes the valid bank result and routes it to the edge PE named by its tag
module fv_pe_bus import fv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic     [NUM_BANKS-1:0] res_valid,
    input  pe_tag_t  [NUM_BANKS-1:0] res_tag,
    input  fv_data_t [NUM_BANKS-1:0] res_data,
    output logic     [NUM_PE-1:0]    pe_valid,
    output fv_data_t [NUM_PE-1:0]    pe_data
);

    logic     sel_valid;
    pe_tag_t  sel_tag;
    fv_data_t sel_data;

    // one result per cycle is expected, the lowest bank wins otherwise
    always_comb begin
        sel_valid = 1'b0;
        sel_tag   = '0;
        sel_data  = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (res_valid[b] && !sel_valid) begin
                sel_valid = 1'b1;
                sel_tag   = res_tag[b];
                sel_data  = res_data[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pe_valid <= '0;
        end else begin
            pe_valid <= '0;
            if (sel_valid) begin
                pe_valid[sel_tag] <= 1'b1;
            end
        end
    end

    // untouched PEs keep the last word they were sent
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            pe_data[sel_tag] <= sel_data;
        end
    end

endmodule

/* fv_sram_top.sv */
// top level of the feature-vector store joining FIFO, memory controller, four banks and PE bus
module fv_sram_top import fv_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  pe_tag_t                  req_tag,
    input  fv_addr_t                 req_addr,
    output logic                     req_full,
    input  fv_count_t                num_fv,
    input  logic     [NUM_BANKS-1:0] fill_valid,
    input  fv_row_t  [NUM_BANKS-1:0] fill_row,
    input  fv_data_t [NUM_BANKS-1:0] fill_data,
    output logic     [NUM_PE-1:0]    pe_valid,
    output fv_data_t [NUM_PE-1:0]    pe_data
);

    fv_req_if req_head ();

    logic     [NUM_BANKS-1:0] busy;
    logic     [NUM_BANKS-1:0] issue;
    pe_tag_t                  issue_tag;
    fv_row_t                  issue_row;
    logic     [NUM_BANKS-1:0] res_valid;
    pe_tag_t  [NUM_BANKS-1:0] res_tag;
    fv_data_t [NUM_BANKS-1:0] res_data;

    fv_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (req_valid),
        .wr_tag   (req_tag),
        .wr_addr  (req_addr),
        .full     (req_full),
        .head     (req_head.fifo_side)
    );

    fv_mem_cntl u_mem_cntl (
        .clk       (clk),
        .rst       (rst),
        .head      (req_head.cntl_side),
        .busy      (busy),
        .issue     (issue),
        .issue_tag (issue_tag),
        .issue_row (issue_row)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        fv_bank_cntl u_bank_cntl (
            .clk        (clk),
            .rst        (rst),
            .num_fv     (num_fv),
            .bank_id    (bank_idx_t'(i)),
            .issue      (issue[i]),
            .issue_tag  (issue_tag),
            .issue_row  (issue_row),
            .fill_valid (fill_valid[i]),
            .fill_row   (fill_row[i]),
            .fill_data  (fill_data[i]),
            .busy       (busy[i]),
            .res_valid  (res_valid[i]),
            .res_tag    (res_tag[i]),
            .res_data   (res_data[i])
        );
    end

    fv_pe_bus u_pe_bus (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_data  (res_data),
        .pe_valid  (pe_valid),
        .pe_data   (pe_data)
    );

endmodule

/* fv_sram_chk.sv */
// concurrent checks on the feature-vector store, bound into the top level for simulation
module fv_sram_chk import fv_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_full,
    input logic                 req_valid,
    input logic [NUM_BANKS-1:0] fill_valid,
    input logic [NUM_BANKS-1:0] res_valid,
    input logic [NUM_PE-1:0]    pe_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // the bus passes on one bank result per cycle, so pe_valid stays one-hot only if
    // no two banks finish together
    pe_valid_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(res_valid))
        else $error("two banks returned a result in the same cycle");

    pe_valid_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> pe_valid == '0)
        else $error("pe_valid is high during reset");

    // a bank result leaves two cycles after the array read that made it
    fill_read_clash: assert property (@(posedge clk) disable iff (rst)
        (res_valid & $past(fill_valid, 2)) == '0)
        else $error("fill and read hit the same bank in one cycle");

    full_write: assert property (@(posedge clk) disable iff (rst) req_full |-> !req_valid)
        else $error("a request was sent while the request FIFO was full");

endmodule

bind fv_sram_top fv_sram_chk chk0 (
    .clk        (clk),
    .rst        (rst),
    .req_full   (req_full),
    .req_valid  (req_valid),
    .fill_valid (fill_valid),
    .res_valid  (res_valid),
    .pe_valid   (pe_valid)
);

/* fv_sram_tb.sv */
// testbench for the feature-vector store, applies the stimulus table and checks every PE result
module fv_sram_tb import fv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 300;
    localparam int NUM_ENTRIES = 21;

    typedef enum logic [2:0] {K_FILL, K_READ, K_COUNT, K_SPREAD, K_STRIDE} kind_t;

    // spread and stride entries send val reads, stepping the address by 1 or by 4
    typedef struct packed {
        kind_t     kind;
        fv_addr_t  addr;
        fv_count_t val;
        pe_tag_t   tag;
    } entry_t;

    localparam entry_t STIM [NUM_ENTRIES] = '{
        '{K_COUNT,  8'h00, 9'd256, 2'd0},
        '{K_FILL,   8'h05, 9'd0,   2'd0},
        '{K_READ,   8'h05, 9'd0,   2'd2},
        '{K_READ,   8'ha2, 9'd0,   2'd3},
        '{K_READ,   8'h3f, 9'd0,   2'd1},
        '{K_SPREAD, 8'h10, 9'd8,   2'd0},
        '{K_STRIDE, 8'h21, 9'd6,   2'd0},
        '{K_COUNT,  8'h00, 9'd100, 2'd0},
        '{K_READ,   8'h63, 9'd0,   2'd0},
        '{K_READ,   8'h64, 9'd0,   2'd1},
        '{K_READ,   8'hfe, 9'd0,   2'd2},
        '{K_SPREAD, 8'h60, 9'd8,   2'd0},
        '{K_COUNT,  8'h00, 9'd256, 2'd0},
        '{K_FILL,   8'h40, 9'd0,   2'd0},
        '{K_READ,   8'h40, 9'd0,   2'd3},
        '{K_FILL,   8'h44, 9'd0,   2'd0},
        '{K_READ,   8'h44, 9'd0,   2'd1},
        '{K_FILL,   8'h48, 9'd0,   2'd0},
        '{K_READ,   8'h40, 9'd0,   2'd0},
        '{K_READ,   8'h48, 9'd0,   2'd2},
        '{K_STRIDE, 8'h03, 9'd14,  2'd0}
    };

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    pe_tag_t                  req_tag;
    fv_addr_t                 req_addr;
    logic                     req_full;
    fv_count_t                num_fv;
    logic     [NUM_BANKS-1:0] fill_valid;
    fv_row_t  [NUM_BANKS-1:0] fill_row;
    fv_data_t [NUM_BANKS-1:0] fill_data;
    logic     [NUM_PE-1:0]    pe_valid;
    fv_data_t [NUM_PE-1:0]    pe_data;

    fv_data_t ref_mem [2**ADDR_W];
    fv_data_t exp_data_q [$];
    pe_tag_t  exp_tag_q [$];
    pe_tag_t  got_tag;
    int       seed;
    int       data_errs;
    int       tag_errs;
    int       other_errs;
    logic     saw_full;

    fv_sram_top #(
        .FIFO_DEPTH (8)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_tag    (req_tag),
        .req_addr   (req_addr),
        .req_full   (req_full),
        .num_fv     (num_fv),
        .fill_valid (fill_valid),
        .fill_row   (fill_row),
        .fill_data  (fill_data),
        .pe_valid   (pe_valid),
        .pe_data    (pe_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_data(input fv_data_t got, input fv_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: pe_data %h, expected %h", $time, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_tag(input pe_tag_t got, input pe_tag_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: result on PE %0d, expected PE %0d", $time, got, exp);
            tag_errs++;
        end
    endtask

    // ========================================
    // stimulus tasks
    // ========================================
    task automatic send_fill(input fv_addr_t addr);
        bank_idx_t b;
        b = addr[BANK_W-1:0];
        fill_valid[b] = 1'b1;
        fill_row[b]   = addr[ADDR_W-1:BANK_W];
        fill_data[b]  = fv_data_t'($random(seed));
        ref_mem[addr] = fill_data[b];
        @(negedge clk);
        fill_valid = '0;
    endtask

    task automatic send_read(input fv_addr_t addr, input pe_tag_t tag);
        int       waited;
        fv_data_t exp;
        waited = 0;
        while (req_full && waited < WAIT_LIMIT) begin
            saw_full = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (req_full) begin
            $display("at %0t the request FIFO stayed full and a read was not sent", $time);
            other_errs++;
        end else begin
            req_valid = 1'b1;
            req_tag   = tag;
            req_addr  = addr;
            exp_tag_q.push_back(tag);
            if (int'(addr) >= int'(num_fv)) begin
                // reads at or above the count come back as zero
                exp = '0;
            end else begin
                exp = ref_mem[addr];
            end
            exp_data_q.push_back(exp);
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_burst(input fv_addr_t addr, input int n, input int step);
        for (int j = 0; j < n; j++) begin
            send_read(fv_addr_t'(int'(addr) + j * step), pe_tag_t'(j));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_tag_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_tag_q.size() != 0) begin
            $display("at %0t %0d reads were never answered", $time, exp_tag_q.size());
            other_errs++;
            exp_tag_q.delete();
            exp_data_q.delete();
        end
    endtask

    // every pe_valid pulse is matched against the oldest outstanding read
    always @(negedge clk) begin
        if (!rst && pe_valid != '0) begin
            got_tag = '0;
            for (int p = 0; p < NUM_PE; p++) begin
                if (pe_valid[p]) begin
                    got_tag = pe_tag_t'(p);
                end
            end
            if ($countones(pe_valid) != 1) begin
                $display("at %0t more than one PE got a result: %b", $time, pe_valid);
                other_errs++;
            end
            if (exp_tag_q.size() == 0) begin
                $display("at %0t a result arrived with no read outstanding", $time);
                other_errs++;
            end else begin
                check_tag(got_tag, exp_tag_q.pop_front());
                check_data(pe_data[got_tag], exp_data_q.pop_front());
            end
        end
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        seed       = 32'h2461_8292;
        data_errs  = 0;
        tag_errs   = 0;
        other_errs = 0;
        saw_full   = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_tag    = '0;
        req_addr   = '0;
        num_fv     = 9'd256;
        fill_valid = '0;
        fill_row   = '0;
        fill_data  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fill the whole store, all four banks in parallel
        for (int r = 0; r < 2**ROW_W; r++) begin
            fill_valid = '1;
            for (int b = 0; b < NUM_BANKS; b++) begin
                fill_row[b]  = fv_row_t'(r);
                fill_data[b] = fv_data_t'($random(seed));
                ref_mem[{fv_row_t'(r), bank_idx_t'(b)}] = fill_data[b];
            end
            @(negedge clk);
        end
        fill_valid = '0;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            case (STIM[i].kind)
                K_FILL:   send_fill(STIM[i].addr);
                K_READ:   send_read(STIM[i].addr, STIM[i].tag);
                K_SPREAD: send_burst(STIM[i].addr, int'(STIM[i].val), 1);
                K_STRIDE: send_burst(STIM[i].addr, int'(STIM[i].val), NUM_BANKS);
                default: begin
                    drain();
                    num_fv = STIM[i].val;
                end
            endcase
        end

        drain();
        // a few idle cycles so that a stray extra result is caught
        repeat (20) @(negedge clk);
        if (!saw_full) begin
            $display("req_full was never raised by the long burst");
            other_errs++;
        end
        $display("errors: data %0d, tag %0d, other %0d", data_errs, tag_errs, other_errs);
        if (data_errs + tag_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* all.f */
fv_pkg.sv
fv_req_if.sv
fv_req_fifo.sv
fv_mem_cntl.sv
fv_bank_cntl.sv
fv_pe_bus.sv
fv_sram_top.sv
fv_sram_chk.sv
fv_sram_tb.sv

/* Makefile */
TOP = fv_sram_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
